// ==== dv/axi_lite_tasks.svh ====
////////////////////////////////////////
// AXI4-Lite master tasks and reference model functions for the analog
// path testbench. Included inside the testbench module body.
////////////////////////////////////////

`ifndef AXI_LITE_TASKS_SVH
`define AXI_LITE_TASKS_SVH

//////////////////////////////////////
// Reference model
//////////////////////////////////////

// Negative-slope offset code, upper 14 bits of the ADC word
function automatic sample_t model_adc(adc_raw_t raw);
  logic [13:0] code;
  code = raw[15:2];
  return sample_t'(code ^ 14'h1FFF);  // Flip all but the MSB
endfunction

function automatic sample_t model_gain(sample_t smp, gain_t gain);
  int prod;
  int q;
  prod = int'(smp) * int'(gain);
  q    = prod >>> 8;                 // Q8.8 back to integer, floor
  if (q > 8191) q = 8191;
  if (q < -8192) q = -8192;
  return sample_t'(q);
endfunction

function automatic sample_t model_sum(sample_t lvl, sample_t fb);
  int t;
  t = int'(lvl) + int'(fb);
  if (t > 8191) t = 8191;
  if (t < -8192) t = -8192;
  return sample_t'(t);
endfunction

function automatic dac_code_t model_dac(sample_t smp);
  return dac_code_t'(smp) ^ 14'h1FFF;
endfunction

// Loop value that maps onto itself, iterated from the level
function automatic sample_t fixed_point(sample_t lvl, gain_t gain);
  sample_t x;
  sample_t nx;
  x = lvl;
  for (int i = 0; i < 200; i++) begin
    nx = model_sum(lvl, model_gain(x, gain));
    if (nx == x) break;
    x = nx;
  end
  return x;
endfunction

//////////////////////////////////////
// Bus transfers
//////////////////////////////////////

// Write one word; hold > 0 keeps bready low that many cycles
task automatic write_reg(input axi_addr_t addr, input axi_data_t data, input axi_strb_t strb,
                         input axi_resp_t exp_resp, input int hold);
  axi_resp_t first;
  @(posedge adc_clk);
  s_awvalid <= 1'b1;
  s_awaddr  <= addr;
  s_wvalid  <= 1'b1;
  s_wdata   <= data;
  s_wstrb   <= strb;
  s_bready  <= (hold == 0);
  do @(posedge adc_clk); while (!s_awready);
  s_awvalid <= 1'b0;
  s_wvalid  <= 1'b0;
  do @(posedge adc_clk); while (!s_bvalid);
  first = s_bresp;
  repeat (hold) begin
    @(posedge adc_clk);
    assert (s_bvalid && s_bresp == first)
      else report_failure("write response changed or dropped while bready was low");
  end
  if (hold > 0) begin
    s_bready <= 1'b1;
    @(posedge adc_clk);  // Response taken here
  end
  assert (first == exp_resp) else report_mismatch("s_bresp_o", first, exp_resp);
endtask

// Read one word and compare data and response
task automatic read_expect(input axi_addr_t addr, input axi_data_t exp_data,
                           input axi_resp_t exp_resp, input int hold);
  axi_data_t data;
  axi_resp_t resp;
  @(posedge adc_clk);
  s_arvalid <= 1'b1;
  s_araddr  <= addr;
  s_rready  <= (hold == 0);
  do @(posedge adc_clk); while (!s_arready);
  s_arvalid <= 1'b0;
  do @(posedge adc_clk); while (!s_rvalid);
  data = s_rdata;
  resp = s_rresp;
  repeat (hold) begin
    @(posedge adc_clk);
    assert (s_rvalid && s_rdata == data && s_rresp == resp)
      else report_failure("read response changed or dropped while rready was low");
  end
  if (hold > 0) begin
    s_rready <= 1'b1;
    @(posedge adc_clk);
  end
  assert (data == exp_data) else report_mismatch("s_rdata_o", data, exp_data);
  assert (resp == exp_resp) else report_mismatch("s_rresp_o", resp, exp_resp);
endtask

`endif

// ==== dv/rp_analog_tb.sv ====
////////////////////////////////////////
// Testbench of the analog path. Acts as AXI4-Lite master, drives random
// ADC words and checks the DAC ports against a cycle model.
////////////////////////////////////////

`timescale 1ns/10ps

module rp_analog_tb;

  import rp_analog_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int MAX_CYCLES = 2000;  // About 800 cycles of tests plus margin

  logic      adc_clk;
  logic      arst_n_i;
  adc_raw_t  adc_dat_a, adc_dat_b;
  dac_code_t dac_a, dac_b;
  logic      s_awvalid, s_awready, s_wvalid, s_wready, s_bvalid, s_bready;
  logic      s_arvalid, s_arready, s_rvalid, s_rready;
  axi_addr_t s_awaddr, s_araddr;
  axi_data_t s_wdata, s_rdata;
  axi_strb_t s_wstrb;
  axi_resp_t s_bresp, s_rresp;

  // Shadow register fields and model pipeline
  logic      sh_loop;
  gain_t     sh_gain_a, sh_gain_b;
  sample_t   sh_level_a, sh_level_b;
  sample_t   m_s1_a, m_s1_b, m_fb_a, m_fb_b, m_sum_a, m_sum_b;
  dac_code_t m_dac_a, m_dac_b;

  rp_analog_top rp_analog_top_inst (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b),
    .s_awvalid_i (s_awvalid),
    .s_awready_o (s_awready),
    .s_awaddr_i  (s_awaddr),
    .s_wvalid_i  (s_wvalid),
    .s_wready_o  (s_wready),
    .s_wdata_i   (s_wdata),
    .s_wstrb_i   (s_wstrb),
    .s_bvalid_o  (s_bvalid),
    .s_bready_i  (s_bready),
    .s_bresp_o   (s_bresp),
    .s_arvalid_i (s_arvalid),
    .s_arready_o (s_arready),
    .s_araddr_i  (s_araddr),
    .s_rvalid_o  (s_rvalid),
    .s_rready_i  (s_rready),
    .s_rdata_o   (s_rdata),
    .s_rresp_o   (s_rresp)
  );

  task automatic report_mismatch(input string name, input int unsigned got,
                                 input int unsigned exp);
    $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_failure(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  `include "axi_lite_tasks.svh"

  function automatic axi_data_t sext(sample_t v);
    return axi_data_t'(int'(v));
  endfunction

  // Register view as the bus sees it
  function automatic axi_data_t shadow_view(axi_addr_t addr);
    case (addr)
      REG_CTRL:    return {31'b0, sh_loop};
      REG_GAIN_A:  return {16'b0, sh_gain_a};
      REG_GAIN_B:  return {16'b0, sh_gain_b};
      REG_LEVEL_A: return sext(sh_level_a);
      REG_LEVEL_B: return sext(sh_level_b);
      default:     return '0;
    endcase
  endfunction

  function automatic axi_data_t merge_bytes(axi_data_t old_v, axi_data_t new_v, axi_strb_t strb);
    axi_data_t r;
    for (int i = 0; i < 4; i++) r[8*i +: 8] = strb[i] ? new_v[8*i +: 8] : old_v[8*i +: 8];
    return r;
  endfunction

  // Clock source
  initial begin
    adc_clk = 1'b0;
    forever #(CLK_PERIOD/2) adc_clk = ~adc_clk;
  end

  initial begin
    #(MAX_CYCLES * CLK_PERIOD);
    report_failure("timeout, the run did not finish in time");
  end

  ////////////////////////////////////////
  // Cycle model of the three stages
  ////////////////////////////////////////

  always @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sh_loop    <= 1'b0;
      sh_gain_a  <= '0;
      sh_gain_b  <= '0;
      sh_level_a <= '0;
      sh_level_b <= '0;
      m_s1_a     <= '0;
      m_s1_b     <= '0;
      m_fb_a     <= '0;
      m_fb_b     <= '0;
      m_sum_a    <= '0;
      m_sum_b    <= '0;
      m_dac_a    <= 14'h1FFF;  // Code of sample zero
      m_dac_b    <= 14'h1FFF;
    end else begin : model_step
      axi_data_t merged;
      merged = merge_bytes(shadow_view(s_awaddr), s_wdata, s_wstrb);
      if (s_awvalid && s_wvalid && s_awready) begin  // Write accepted
        case (s_awaddr)
          REG_CTRL:    sh_loop    <= merged[0];
          REG_GAIN_A:  sh_gain_a  <= gain_t'(merged[15:0]);
          REG_GAIN_B:  sh_gain_b  <= gain_t'(merged[15:0]);
          REG_LEVEL_A: sh_level_a <= sample_t'(merged[13:0]);
          REG_LEVEL_B: sh_level_b <= sample_t'(merged[13:0]);
          default:     ;
        endcase
      end
      m_s1_a  <= sh_loop ? m_sum_a : model_adc(adc_dat_a);
      m_s1_b  <= sh_loop ? m_sum_b : model_adc(adc_dat_b);
      m_fb_a  <= model_gain(m_s1_a, sh_gain_a);
      m_fb_b  <= model_gain(m_s1_b, sh_gain_b);
      m_sum_a <= model_sum(sh_level_a, m_fb_a);
      m_sum_b <= model_sum(sh_level_b, m_fb_b);
      m_dac_a <= model_dac(model_sum(sh_level_a, m_fb_a));
      m_dac_b <= model_dac(model_sum(sh_level_b, m_fb_b));
    end
  end

  dac_a_check: assert property (@(posedge adc_clk) disable iff (!arst_n_i) dac_a == m_dac_a)
    else report_mismatch("dac_a_o", $sampled(dac_a), $sampled(m_dac_a));
  dac_b_check: assert property (@(posedge adc_clk) disable iff (!arst_n_i) dac_b == m_dac_b)
    else report_mismatch("dac_b_o", $sampled(dac_b), $sampled(m_dac_b));

  // AW and W ready pulse together
  ready_pair_check: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
                                     s_wready == s_awready)
    else report_mismatch("s_wready_o", $sampled(s_wready), $sampled(s_awready));

  // Free-running random ADC words
  task automatic run_cycles(input int n);
    repeat (n) begin
      @(posedge adc_clk);
      adc_dat_a <= adc_raw_t'($urandom);
      adc_dat_b <= adc_raw_t'($urandom);
    end
  endtask

  task automatic expect_dac(input sample_t va, input sample_t vb);
    assert (dac_a == model_dac(va)) else report_mismatch("dac_a_o", dac_a, model_dac(va));
    assert (dac_b == model_dac(vb)) else report_mismatch("dac_b_o", dac_b, model_dac(vb));
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    sample_t   lvls[4];
    axi_addr_t regs[5];
    sample_t   fp_a;
    sample_t   fp_b;
    void'($urandom(32'hcfa58f5c));
    arst_n_i  = 1'b0;
    adc_dat_a = '0;
    adc_dat_b = '0;
    s_awvalid = 1'b0;
    s_awaddr  = '0;
    s_wvalid  = 1'b0;
    s_wdata   = '0;
    s_wstrb   = '0;
    s_bready  = 1'b1;
    s_arvalid = 1'b0;
    s_araddr  = '0;
    s_rready  = 1'b1;
    lvls      = '{SAMPLE_MAX, SAMPLE_MIN, 14'sd0, 14'sd1234};
    regs      = '{REG_CTRL, REG_GAIN_A, REG_GAIN_B, REG_LEVEL_A, REG_LEVEL_B};
    repeat (2) @(posedge adc_clk);
    arst_n_i <= 1'b1;

    // Reset state
    @(posedge adc_clk);
    expect_dac(14'sd0, 14'sd0);
    foreach (regs[i]) read_expect(regs[i], 32'h0, RESP_OKAY, 0);

    // Register access, strobes, back-pressure, unmapped address
    write_reg(REG_GAIN_A, 32'h0000_1234, 4'hF, RESP_OKAY, 0);
    write_reg(REG_GAIN_A, 32'hFFFF_ABCD, 4'b0010, RESP_OKAY, 0);
    read_expect(REG_GAIN_A, 32'h0000_AB34, RESP_OKAY, 0);
    write_reg(REG_LEVEL_B, 32'h0000_2000, 4'hF, RESP_OKAY, 3);
    read_expect(REG_LEVEL_B, 32'hFFFF_E000, RESP_OKAY, 3);  // Sign-extended
    write_reg(REG_CTRL, 32'h1, 4'hF, RESP_OKAY, 0);
    read_expect(REG_CTRL, 32'h1, RESP_OKAY, 0);
    write_reg(REG_CTRL, 32'h0, 4'hF, RESP_OKAY, 0);
    write_reg(5'h14, 32'hDEAD_BEEF, 4'hF, RESP_SLVERR, 0);
    read_expect(5'h14, 32'h0, RESP_SLVERR, 0);

    // Gain zero, DAC shows the level
    write_reg(REG_GAIN_A, 32'h0, 4'hF, RESP_OKAY, 0);
    foreach (lvls[i]) begin
      write_reg(REG_LEVEL_A, sext(lvls[i]), 4'hF, RESP_OKAY, 0);
      write_reg(REG_LEVEL_B, sext(~lvls[i]), 4'hF, RESP_OKAY, 0);
      run_cycles(4);
      expect_dac(lvls[i], ~lvls[i]);
    end

    // Random words and gains, then saturating gains
    write_reg(REG_LEVEL_A, sext(14'sd300), 4'hF, RESP_OKAY, 0);
    repeat (8) begin
      write_reg(REG_GAIN_A, {16'h0, 16'($urandom)}, 4'hF, RESP_OKAY, 0);
      write_reg(REG_GAIN_B, {16'h0, 16'($urandom)}, 4'hF, RESP_OKAY, 0);
      run_cycles(40);
    end
    write_reg(REG_GAIN_A, 32'h7FFF, 4'hF, RESP_OKAY, 0);
    write_reg(REG_GAIN_B, 32'h8000, 4'hF, RESP_OKAY, 0);
    run_cycles(40);

    // Loopback, level only, then settling to the fixed point
    write_reg(REG_GAIN_A, 32'h0, 4'hF, RESP_OKAY, 0);
    write_reg(REG_GAIN_B, 32'h0, 4'hF, RESP_OKAY, 0);
    write_reg(REG_LEVEL_A, sext(14'sd1000), 4'hF, RESP_OKAY, 0);
    write_reg(REG_LEVEL_B, sext(-14'sd2000), 4'hF, RESP_OKAY, 0);
    write_reg(REG_CTRL, 32'h1, 4'hF, RESP_OKAY, 0);
    run_cycles(6);
    expect_dac(14'sd1000, -14'sd2000);
    write_reg(REG_GAIN_A, 32'd64, 4'hF, RESP_OKAY, 0);  // Quarter gain
    write_reg(REG_GAIN_B, 32'd64, 4'hF, RESP_OKAY, 0);
    fp_a = fixed_point(14'sd1000, 16'sd64);
    fp_b = fixed_point(-14'sd2000, 16'sd64);
    run_cycles(30);
    repeat (10) begin
      expect_dac(fp_a, fp_b);
      run_cycles(1);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== logic/adc_frontend.sv ====
////////////////////////////////////////
// Pipeline stage 1. Turns raw ADC words into signed samples, or feeds
// the mixer sum back in when digital loopback is on.
////////////////////////////////////////

`timescale 1ns/10ps

module adc_frontend (
  input  logic                   adc_clk,
  input  logic                   arst_n_i,
  input  rp_analog_pkg::adc_raw_t adc_dat_a_i,    // Channel A raw word
  input  rp_analog_pkg::adc_raw_t adc_dat_b_i,    // Channel B raw word
  input  logic                   digital_loop_i, // Loopback enable
  input  rp_analog_pkg::sample_t  dac_sum_a_i,    // Mixer output, A
  input  rp_analog_pkg::sample_t  dac_sum_b_i,    // Mixer output, B
  output rp_analog_pkg::sample_t  sample_a_o,
  output rp_analog_pkg::sample_t  sample_b_o
);

  import rp_analog_pkg::*;

  // Drop LSBs, then offset code to two's complement
  function automatic sample_t adc_to_sample(adc_raw_t raw);
    logic [SAMPLE_W-1:0] code;
    code = raw[ADC_DROP_BITS +: SAMPLE_W];
    // Negative slope: MSB stays, rest inverted
    return sample_t'({code[SAMPLE_W-1], ~code[SAMPLE_W-2:0]});
  endfunction

  sample_t sel_a;  // Stage input after loop mux
  sample_t sel_b;

  always_comb begin
    sel_a = digital_loop_i ? dac_sum_a_i : adc_to_sample(adc_dat_a_i);
    sel_b = digital_loop_i ? dac_sum_b_i : adc_to_sample(adc_dat_b_i);
  end

  //////////////////////////////////////
  // Stage register
  //////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sample_a_o <= '0;  // Sample zero
      sample_b_o <= '0;
    end else begin
      sample_a_o <= sel_a;
      sample_b_o <= sel_b;
    end
  end

endmodule

// ==== logic/axi_lite_regs.sv ====
////////////////////////////////////////
// AXI4-Lite slave with the loopback bit, per-channel gains and generator
// levels. One write and one read may be outstanding at once.
////////////////////////////////////////

`timescale 1ns/10ps

module axi_lite_regs (
  input  logic                    adc_clk,
  input  logic                    arst_n_i,
  // Write address
  input  logic                    s_awvalid_i,
  output logic                    s_awready_o,
  input  rp_analog_pkg::axi_addr_t s_awaddr_i,
  // Write data
  input  logic                    s_wvalid_i,
  output logic                    s_wready_o,
  input  rp_analog_pkg::axi_data_t s_wdata_i,
  input  rp_analog_pkg::axi_strb_t s_wstrb_i,
  // Write response
  output logic                    s_bvalid_o,
  input  logic                    s_bready_i,
  output rp_analog_pkg::axi_resp_t s_bresp_o,
  // Read address
  input  logic                    s_arvalid_i,
  output logic                    s_arready_o,
  input  rp_analog_pkg::axi_addr_t s_araddr_i,
  // Read data
  output logic                    s_rvalid_o,
  input  logic                    s_rready_i,
  output rp_analog_pkg::axi_data_t s_rdata_o,
  output rp_analog_pkg::axi_resp_t s_rresp_o,
  // Fields
  output logic                    digital_loop_o,
  output rp_analog_pkg::gain_t     gain_a_o,
  output rp_analog_pkg::gain_t     gain_b_o,
  output rp_analog_pkg::sample_t   level_a_o,
  output rp_analog_pkg::sample_t   level_b_o
);

  import rp_analog_pkg::*;

  logic      wr_ready_q;  // Shared AW/W ready pulse
  logic      wr_fire;
  logic      rd_fire;
  axi_data_t wr_merged;   // Old value with strobed bytes replaced

  // Exact match on the five mapped words
  function automatic logic reg_mapped(axi_addr_t addr);
    return (addr == REG_CTRL)    || (addr == REG_GAIN_A) || (addr == REG_GAIN_B) ||
           (addr == REG_LEVEL_A) || (addr == REG_LEVEL_B);
  endfunction

  // Read view of the register file, zero when unmapped
  function automatic axi_data_t reg_read(axi_addr_t addr);
    axi_data_t val;
    case (addr)
      REG_CTRL:    val = {{(AXI_DATA_W-1){1'b0}}, digital_loop_o};
      REG_GAIN_A:  val = {{(AXI_DATA_W-GAIN_W){1'b0}}, gain_a_o};
      REG_GAIN_B:  val = {{(AXI_DATA_W-GAIN_W){1'b0}}, gain_b_o};
      REG_LEVEL_A: val = {{(AXI_DATA_W-SAMPLE_W){level_a_o[SAMPLE_W-1]}}, level_a_o}; // Sign ext
      REG_LEVEL_B: val = {{(AXI_DATA_W-SAMPLE_W){level_b_o[SAMPLE_W-1]}}, level_b_o};
      default:     val = '0;
    endcase
    return val;
  endfunction

  // Byte lane merge
  function automatic axi_data_t apply_strb(axi_data_t old_val, axi_data_t new_val,
                                           axi_strb_t strb);
    axi_data_t res;
    int        i;
    for (i = 0; i < AXI_STRB_W; i++) begin
      res[8*i +: 8] = strb[i] ? new_val[8*i +: 8] : old_val[8*i +: 8];
    end
    return res;
  endfunction

  assign s_awready_o = wr_ready_q;
  assign s_wready_o  = wr_ready_q;
  assign wr_fire     = wr_ready_q & s_awvalid_i & s_wvalid_i;
  assign rd_fire     = s_arready_o & s_arvalid_i;

  always_comb begin
    wr_merged = apply_strb(reg_read(s_awaddr_i), s_wdata_i, s_wstrb_i);
  end

  //////////////////////////////////////
  // Write channel
  //////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ready_q <= 1'b0;
      s_bvalid_o <= 1'b0;
      s_bresp_o  <= RESP_OKAY;
    end else begin
      // One-cycle pulse, never while a response waits
      wr_ready_q <= s_awvalid_i & s_wvalid_i & ~s_bvalid_o & ~wr_ready_q;
      if (wr_fire) begin
        s_bvalid_o <= 1'b1;
        s_bresp_o  <= reg_mapped(s_awaddr_i) ? RESP_OKAY : RESP_SLVERR;
      end else if (s_bready_i) begin
        s_bvalid_o <= 1'b0;  // Response taken
      end
    end
  end

  // Field update on the handshake cycle
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      digital_loop_o <= 1'b0;
      gain_a_o       <= '0;
      gain_b_o       <= '0;
      level_a_o      <= '0;
      level_b_o      <= '0;
    end else if (wr_fire) begin
      case (s_awaddr_i)
        REG_CTRL:    digital_loop_o <= wr_merged[0];
        REG_GAIN_A:  gain_a_o       <= gain_t'(wr_merged[GAIN_W-1:0]);
        REG_GAIN_B:  gain_b_o       <= gain_t'(wr_merged[GAIN_W-1:0]);
        REG_LEVEL_A: level_a_o      <= sample_t'(wr_merged[SAMPLE_W-1:0]);
        REG_LEVEL_B: level_b_o      <= sample_t'(wr_merged[SAMPLE_W-1:0]);
        default:     ;  // Unmapped, nothing changes
      endcase
    end
  end

  //////////////////////////////////////
  // Read channel
  //////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s_arready_o <= 1'b0;
      s_rvalid_o  <= 1'b0;
      s_rdata_o   <= '0;
      s_rresp_o   <= RESP_OKAY;
    end else begin
      s_arready_o <= s_arvalid_i & ~s_rvalid_o & ~s_arready_o;
      if (rd_fire) begin
        s_rvalid_o <= 1'b1;
        s_rdata_o  <= reg_read(s_araddr_i);
        s_rresp_o  <= reg_mapped(s_araddr_i) ? RESP_OKAY : RESP_SLVERR;
      end else if (s_rready_i) begin
        s_rvalid_o <= 1'b0;  // Data held until taken
      end
    end
  end

endmodule

// ==== logic/dac_mixer.sv ====
////////////////////////////////////////
// Pipeline stage 3. Generator level plus feedback with saturation; gives
// the signed sum for loopback and the negative-slope DAC code.
////////////////////////////////////////

`timescale 1ns/10ps

module dac_mixer (
  input  logic                    adc_clk,
  input  logic                    arst_n_i,
  input  rp_analog_pkg::sample_t   fb_a_i,       // Controller term
  input  rp_analog_pkg::sample_t   fb_b_i,
  input  rp_analog_pkg::sample_t   level_a_i,    // Generator DC level
  input  rp_analog_pkg::sample_t   level_b_i,
  output rp_analog_pkg::sample_t   dac_sum_a_o,  // Saturated sum, to frontend
  output rp_analog_pkg::sample_t   dac_sum_b_o,
  output rp_analog_pkg::dac_code_t dac_a_o,      // DAC code, channel A
  output rp_analog_pkg::dac_code_t dac_b_o
);

  import rp_analog_pkg::*;

  // Sum in one extra bit, clamp on overflow
  function automatic sample_t sat_add(sample_t lvl, sample_t fb);
    logic signed [SUM_W-1:0] sum;
    sample_t                 res;
    sum = lvl + fb;
    if (sum[SUM_W-1] != sum[SUM_W-2]) begin
      res = sum[SUM_W-1] ? SAMPLE_MIN : SAMPLE_MAX;  // Sign bit tells direction
    end else begin
      res = sample_t'(sum[SAMPLE_W-1:0]);
    end
    return res;
  endfunction

  // Two's complement back to negative-slope offset code
  function automatic dac_code_t to_dac_code(sample_t smp);
    return {smp[SAMPLE_W-1], ~smp[SAMPLE_W-2:0]};
  endfunction

  sample_t sum_a;
  sample_t sum_b;

  always_comb begin
    sum_a = sat_add(level_a_i, fb_a_i);
    sum_b = sat_add(level_b_i, fb_b_i);
  end

  //////////////////////////////////////
  // Output registers
  //////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dac_sum_a_o <= '0;
      dac_sum_b_o <= '0;
      dac_a_o     <= DAC_ZERO_CODE;  // Code of sample zero
      dac_b_o     <= DAC_ZERO_CODE;
    end else begin
      dac_sum_a_o <= sum_a;
      dac_sum_b_o <= sum_b;
      dac_a_o     <= to_dac_code(sum_a);
      dac_b_o     <= to_dac_code(sum_b);
    end
  end

endmodule

// ==== logic/p_controller.sv ====
////////////////////////////////////////
// Pipeline stage 2. Proportional-only feedback per channel: sample times
// Q8.8 gain, scaled back and clamped to the sample range.
////////////////////////////////////////

`timescale 1ns/10ps

module p_controller (
  input  logic                  adc_clk,
  input  logic                  arst_n_i,
  input  rp_analog_pkg::sample_t sample_a_i,
  input  rp_analog_pkg::sample_t sample_b_i,
  input  rp_analog_pkg::gain_t   gain_a_i,   // Q8.8, 256 is unity
  input  rp_analog_pkg::gain_t   gain_b_i,
  output rp_analog_pkg::sample_t fb_a_o,     // Feedback term to mixer
  output rp_analog_pkg::sample_t fb_b_o
);

  import rp_analog_pkg::*;

  // Multiply, drop fraction bits, saturate
  function automatic sample_t scale_sat(sample_t smp, gain_t gain);
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] shifted;
    sample_t                  res;
    prod    = smp * gain;                // Both signed, full width
    shifted = prod >>> GAIN_FRAC_BITS;   // Arithmetic, keeps sign
    if (shifted > SAMPLE_MAX) begin
      res = SAMPLE_MAX;
    end else if (shifted < SAMPLE_MIN) begin
      res = SAMPLE_MIN;
    end else begin
      res = sample_t'(shifted[SAMPLE_W-1:0]);  // In range, plain truncation
    end
    return res;
  endfunction

  sample_t fb_a;
  sample_t fb_b;

  always_comb begin
    fb_a = scale_sat(sample_a_i, gain_a_i);
    fb_b = scale_sat(sample_b_i, gain_b_i);
  end

  //////////////////////////////////////
  // Stage register
  //////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fb_a_o <= '0;
      fb_b_o <= '0;
    end else begin
      fb_a_o <= fb_a;
      fb_b_o <= fb_b;
    end
  end

endmodule

// ==== logic/rp_analog_pkg.sv ====
////////////////////////////////////////
// Shared widths, sample types, register map and AXI4-Lite response codes
// of the analog path. Imported by every RTL block of the design.
////////////////////////////////////////

package rp_analog_pkg;

  //////////////////////////////////////
  // Widths
  //////////////////////////////////////

  localparam int ADC_W      = 16;                 // Raw ADC word
  localparam int SAMPLE_W   = 14;                 // Converter resolution
  localparam int GAIN_W     = 16;                 // Q8.8 gain
  localparam int PROD_W     = SAMPLE_W + GAIN_W;  // Full product, no overflow
  localparam int SUM_W      = SAMPLE_W + 1;       // Mixer sum with carry bit
  localparam int AXI_ADDR_W = 5;
  localparam int AXI_DATA_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  // Types with a meaning of their own
  typedef logic        [ADC_W-1:0]      adc_raw_t;
  typedef logic signed [SAMPLE_W-1:0]   sample_t;   // Two's complement
  typedef logic        [SAMPLE_W-1:0]   dac_code_t; // Negative-slope offset code
  typedef logic signed [GAIN_W-1:0]     gain_t;     // 256 is unity
  typedef logic        [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic        [AXI_DATA_W-1:0] axi_data_t;
  typedef logic        [AXI_STRB_W-1:0] axi_strb_t;
  typedef logic        [1:0]            axi_resp_t;

  // Data path constants
  localparam int        ADC_DROP_BITS  = ADC_W - SAMPLE_W; // Unused LSBs of 16-bit ADC
  localparam int        GAIN_FRAC_BITS = 8;
  localparam sample_t   SAMPLE_MAX     = {1'b0, {(SAMPLE_W-1){1'b1}}};
  localparam sample_t   SAMPLE_MIN     = {1'b1, {(SAMPLE_W-1){1'b0}}};
  localparam dac_code_t DAC_ZERO_CODE  = 14'h1FFF;  // Mid scale

  //////////////////////////////////////
  // Register map
  //////////////////////////////////////

  localparam axi_addr_t REG_CTRL    = 5'h00;  // Bit 0 digital loop
  localparam axi_addr_t REG_GAIN_A  = 5'h04;
  localparam axi_addr_t REG_GAIN_B  = 5'h08;
  localparam axi_addr_t REG_LEVEL_A = 5'h0C;
  localparam axi_addr_t REG_LEVEL_B = 5'h10;

  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;

endpackage

// ==== logic/rp_analog_top.sv ====
////////////////////////////////////////
// Analog signal path top level. Frontend, P controller and mixer form a
// three-stage pipeline on adc_clk, set up over AXI4-Lite.
////////////////////////////////////////

`timescale 1ns/10ps

module rp_analog_top (
  input  logic                    adc_clk,      // 125 MHz
  input  logic                    arst_n_i,
  // ADC
  input  rp_analog_pkg::adc_raw_t  adc_dat_a_i,
  input  rp_analog_pkg::adc_raw_t  adc_dat_b_i,
  // DAC, one port per channel
  output rp_analog_pkg::dac_code_t dac_a_o,
  output rp_analog_pkg::dac_code_t dac_b_o,
  // AXI4-Lite slave
  input  logic                    s_awvalid_i,
  output logic                    s_awready_o,
  input  rp_analog_pkg::axi_addr_t s_awaddr_i,
  input  logic                    s_wvalid_i,
  output logic                    s_wready_o,
  input  rp_analog_pkg::axi_data_t s_wdata_i,
  input  rp_analog_pkg::axi_strb_t s_wstrb_i,
  output logic                    s_bvalid_o,
  input  logic                    s_bready_i,
  output rp_analog_pkg::axi_resp_t s_bresp_o,
  input  logic                    s_arvalid_i,
  output logic                    s_arready_o,
  input  rp_analog_pkg::axi_addr_t s_araddr_i,
  output logic                    s_rvalid_o,
  input  logic                    s_rready_i,
  output rp_analog_pkg::axi_data_t s_rdata_o,
  output rp_analog_pkg::axi_resp_t s_rresp_o
);

  import rp_analog_pkg::*;

  logic    digital_loop;
  gain_t   gain_a, gain_b;
  sample_t level_a, level_b;
  sample_t sample_a, sample_b;    // Stage 1 out
  sample_t fb_a, fb_b;            // Stage 2 out
  sample_t dac_sum_a, dac_sum_b;  // Stage 3 out, loopback source

  //////////////////////////////////////
  // Configuration
  //////////////////////////////////////

  axi_lite_regs axi_lite_regs_inst (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .s_awvalid_i    (s_awvalid_i),
    .s_awready_o    (s_awready_o),
    .s_awaddr_i     (s_awaddr_i),
    .s_wvalid_i     (s_wvalid_i),
    .s_wready_o     (s_wready_o),
    .s_wdata_i      (s_wdata_i),
    .s_wstrb_i      (s_wstrb_i),
    .s_bvalid_o     (s_bvalid_o),
    .s_bready_i     (s_bready_i),
    .s_bresp_o      (s_bresp_o),
    .s_arvalid_i    (s_arvalid_i),
    .s_arready_o    (s_arready_o),
    .s_araddr_i     (s_araddr_i),
    .s_rvalid_o     (s_rvalid_o),
    .s_rready_i     (s_rready_i),
    .s_rdata_o      (s_rdata_o),
    .s_rresp_o      (s_rresp_o),
    .digital_loop_o (digital_loop),
    .gain_a_o       (gain_a),
    .gain_b_o       (gain_b),
    .level_a_o      (level_a),
    .level_b_o      (level_b)
  );

  //////////////////////////////////////
  // Data path, one edge per stage
  //////////////////////////////////////

  adc_frontend adc_frontend_inst (
    .adc_clk        (adc_clk),
    .arst_n_i       (arst_n_i),
    .adc_dat_a_i    (adc_dat_a_i),
    .adc_dat_b_i    (adc_dat_b_i),
    .digital_loop_i (digital_loop),
    .dac_sum_a_i    (dac_sum_a),   // Loop closes here
    .dac_sum_b_i    (dac_sum_b),
    .sample_a_o     (sample_a),
    .sample_b_o     (sample_b)
  );

  p_controller p_controller_inst (
    .adc_clk    (adc_clk),
    .arst_n_i   (arst_n_i),
    .sample_a_i (sample_a),
    .sample_b_i (sample_b),
    .gain_a_i   (gain_a),
    .gain_b_i   (gain_b),
    .fb_a_o     (fb_a),
    .fb_b_o     (fb_b)
  );

  dac_mixer dac_mixer_inst (
    .adc_clk     (adc_clk),
    .arst_n_i    (arst_n_i),
    .fb_a_i      (fb_a),
    .fb_b_i      (fb_b),
    .level_a_i   (level_a),
    .level_b_i   (level_b),
    .dac_sum_a_o (dac_sum_a),
    .dac_sum_b_o (dac_sum_b),
    .dac_a_o     (dac_a_o),
    .dac_b_o     (dac_b_o)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the analog path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module rp_analog_tb -f sources.f -o rp_analog_sim

./obj_dir/rp_analog_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
  exit 1
fi
if ! grep -q "All tests passed" sim.log; then
  exit 1
fi
exit 0

// ==== sources.f ====
logic/rp_analog_pkg.sv
logic/adc_frontend.sv
logic/p_controller.sv
logic/dac_mixer.sv
logic/axi_lite_regs.sv
logic/rp_analog_top.sv
+incdir+dv
dv/rp_analog_tb.sv
